// ==== hdl/lcdPkg.sv ====
package lcdPkg;

    typedef logic [7:0] lcdByteT;              // Byte on the LCD data bus
    typedef logic [4:0] lcdAddrT;              // 0..15 line 1, 16..31 line 2

    // Sequencer states
    typedef enum logic [2:0]
    {
        POWER_WAIT,
        INIT,
        IDLE,
        LINE1_ADDR,
        LINE1_CHARS,
        LINE2_ADDR,
        LINE2_CHARS
    } seqStateT;

    // Bus writer states, prefixed to keep them apart from the sequencer's IDLE
    typedef enum logic [1:0]
    {
        WR_IDLE,
        WR_SETUP,
        WR_PULSE,
        WR_SETTLE
    } writerStateT;

    localparam lcdByteT CMD_FUNCTION_SET = 8'h38;  // 8-bit bus, two lines, 5x8 font
    localparam lcdByteT CMD_DISPLAY_ON   = 8'h0C;  // Display on, no cursor
    localparam lcdByteT CMD_CLEAR        = 8'h01;  // Slow command
    localparam lcdByteT CMD_ENTRY_MODE   = 8'h06;  // Increment, no shift
    localparam lcdByteT CMD_LINE1_ADDR   = 8'h80;  // DDRAM address 00h
    localparam lcdByteT CMD_LINE2_ADDR   = 8'hC0;  // DDRAM address 40h

    localparam int INIT_LEN = 4;
    localparam int LINE_LEN = 16;

    localparam lcdByteT BLANK_CHAR = 8'h20;        // ASCII space

endpackage

// ==== hdl/lcdCmdIf.sv ====
`timescale 1ns/1ns

interface lcdCmdIf;

    logic            valid;         // Command offered by the sequencer
    logic            rs;            // High marks a character
    lcdPkg::lcdByteT data;
    logic            ready;         // Writer can take a command

    modport src
    (
        output valid,
        output rs,
        output data,
        input  ready
    );

    modport snk
    (
        input  valid,
        input  rs,
        input  data,
        output ready
    );

endinterface

// ==== hdl/lcdScreenBuffer.sv ====
`timescale 1ns/1ns

module lcdScreenBuffer
(
    input  logic            iCLK,
    input  logic            iRST_N,
    input  logic            wrEn,
    input  lcdPkg::lcdAddrT wrAddr,
    input  lcdPkg::lcdByteT wrChar,
    input  lcdPkg::lcdAddrT rdAddr,
    output lcdPkg::lcdByteT rdChar
);

    localparam int DEPTH = 2 * lcdPkg::LINE_LEN;

    lcdPkg::lcdByteT screen [DEPTH];            // One entry per character cell

    ////////////////////////////////////////////////////////////
    // Host write port

    always_ff @(posedge iCLK or negedge iRST_N)
    begin
        if (!iRST_N)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                screen[i] <= lcdPkg::BLANK_CHAR;  // Blank screen after reset
            end
        end
        else if (wrEn)
        begin
            screen[wrAddr] <= wrChar;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequencer read port

    // Answers in the same cycle so the sequencer
    // can capture the character as it offers it
    assign rdChar = screen[rdAddr];

    wrAddrKnown: assert property (
        @(posedge iCLK) disable iff (!iRST_N)
        wrEn |-> !$isunknown(wrAddr)
    )
    else
    begin
        $error("lcdScreenBuffer: write with unknown address");
    end

endmodule

// ==== hdl/lcdSequencer.sv ====
`timescale 1ns/1ns

module lcdSequencer
#(
    parameter int POWER_WAIT_CYCLES = 1_000_000
)
(
    input  logic            iCLK,
    input  logic            iRST_N,
    input  logic            refresh,
    input  lcdPkg::lcdByteT rdChar,
    output lcdPkg::lcdAddrT rdAddr,
    output logic            busy,
    lcdCmdIf.src            cmd
);

    localparam int INIT_W = $clog2(lcdPkg::INIT_LEN);
    localparam int CHAR_W = $clog2(lcdPkg::LINE_LEN);
    localparam int WAIT_W = (POWER_WAIT_CYCLES > 1) ? $clog2(POWER_WAIT_CYCLES) : 1;

    lcdPkg::seqStateT state;
    logic [WAIT_W-1:0] waitCnt;                 // Power-on delay
    logic [INIT_W-1:0] initIdx;
    logic [CHAR_W-1:0] charIdx;                 // Column within the current line
    logic              pending;                 // One remembered repaint request

    logic              cmdValid;
    logic              cmdRs;
    lcdPkg::lcdByteT   cmdData;
    logic              fire;
    logic              offer;                   // State has an item to send
    logic              nextRs;
    lcdPkg::lcdByteT   nextData;
    lcdPkg::lcdByteT   initCmd;

    assign fire      = cmdValid && cmd.ready;
    assign cmd.valid = cmdValid;
    assign cmd.rs    = cmdRs;
    assign cmd.data  = cmdData;
    assign busy      = (state != lcdPkg::IDLE);
    assign rdAddr    = lcdPkg::lcdAddrT'({(state == lcdPkg::LINE2_CHARS), charIdx});

    ////////////////////////////////////////////////////////////
    // Item selection

    always_comb
    begin
        case (initIdx)
            0:       initCmd = lcdPkg::CMD_FUNCTION_SET;
            1:       initCmd = lcdPkg::CMD_DISPLAY_ON;
            2:       initCmd = lcdPkg::CMD_CLEAR;
            default: initCmd = lcdPkg::CMD_ENTRY_MODE;
        endcase
    end

    always_comb
    begin
        offer    = 1'b1;
        nextRs   = 1'b0;
        nextData = lcdPkg::CMD_LINE1_ADDR;
        case (state)
            lcdPkg::INIT:        nextData = initCmd;
            lcdPkg::LINE2_ADDR:  nextData = lcdPkg::CMD_LINE2_ADDR;
            lcdPkg::LINE1_CHARS,
            lcdPkg::LINE2_CHARS:
            begin
                nextRs   = 1'b1;
                nextData = rdChar;              // Buffer read at presentation
            end
            lcdPkg::LINE1_ADDR:  nextData = lcdPkg::CMD_LINE1_ADDR;
            default:             offer    = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Offer register and state machine

    always_ff @(posedge iCLK or negedge iRST_N)
    begin
        if (!iRST_N)
        begin
            state    <= lcdPkg::POWER_WAIT;
            waitCnt  <= '0;
            initIdx  <= '0;
            charIdx  <= '0;
            pending  <= 1'b0;
            cmdValid <= 1'b0;
            cmdRs    <= 1'b0;
            cmdData  <= '0;
        end
        else
        begin
            if (!cmdValid && offer)
            begin
                cmdValid <= 1'b1;               // Held until the writer takes it
                cmdRs    <= nextRs;
                cmdData  <= nextData;
            end
            else if (fire)
            begin
                cmdValid <= 1'b0;
            end

            if (state == lcdPkg::IDLE && pending)
                pending <= 1'b0;
            else if (refresh)
                pending <= 1'b1;                // Further pulses collapse here

            case (state)
                lcdPkg::POWER_WAIT:
                begin
                    waitCnt <= waitCnt + 1'b1;
                    if (waitCnt == WAIT_W'(POWER_WAIT_CYCLES - 1))
                        state <= lcdPkg::INIT;
                end
                lcdPkg::INIT:
                begin
                    if (fire)
                    begin
                        initIdx <= initIdx + 1'b1;
                        if (initIdx == INIT_W'(lcdPkg::INIT_LEN - 1))
                            state <= lcdPkg::LINE1_ADDR;  // Automatic first repaint
                    end
                end
                lcdPkg::IDLE:
                begin
                    if (pending)
                        state <= lcdPkg::LINE1_ADDR;
                end
                lcdPkg::LINE1_ADDR:
                begin
                    if (fire)
                        state <= lcdPkg::LINE1_CHARS;
                end
                lcdPkg::LINE1_CHARS:
                begin
                    if (fire)
                    begin
                        charIdx <= charIdx + 1'b1;       // Wraps to 0 after the line
                        if (charIdx == CHAR_W'(lcdPkg::LINE_LEN - 1))
                            state <= lcdPkg::LINE2_ADDR;
                    end
                end
                lcdPkg::LINE2_ADDR:
                begin
                    if (fire)
                        state <= lcdPkg::LINE2_CHARS;
                end
                default:
                begin
                    if (fire)
                    begin
                        charIdx <= charIdx + 1'b1;
                        if (charIdx == CHAR_W'(lcdPkg::LINE_LEN - 1))
                            state <= lcdPkg::IDLE;
                    end
                end
            endcase
        end
    end

    cmdHeld: assert property (
        @(posedge iCLK) disable iff (!iRST_N)
        cmd.valid && !cmd.ready |=> cmd.valid && $stable(cmd.data) && $stable(cmd.rs)
    )
    else
    begin
        $error("lcdSequencer: command changed while stalled");
    end

endmodule

// ==== hdl/lcdBusWriter.sv ====
`timescale 1ns/1ns

module lcdBusWriter
#(
    parameter int EN_WIDTH_CYCLES     = 25,
    parameter int SETTLE_CYCLES       = 2_500,
    parameter int CLEAR_SETTLE_CYCLES = 100_000
)
(
    input  logic            iCLK,
    input  logic            iRST_N,
    lcdCmdIf.snk            cmd,
    output lcdPkg::lcdByteT lcdData,
    output logic            lcdRs,
    output logic            lcdEn
);

    localparam int LONGEST = (CLEAR_SETTLE_CYCLES > SETTLE_CYCLES) ?
                             CLEAR_SETTLE_CYCLES : SETTLE_CYCLES;
    localparam int CNT_TOP = (LONGEST > EN_WIDTH_CYCLES) ? LONGEST : EN_WIDTH_CYCLES;
    localparam int CNT_W   = $clog2(CNT_TOP + 1);

    lcdPkg::writerStateT state;
    logic [CNT_W-1:0]    cnt;                  // Shared by pulse and settle
    logic                readyQ;
    logic                isClear;
    logic [CNT_W-1:0]    settleLast;

    assign cmd.ready  = readyQ;
    assign isClear    = !lcdRs && (lcdData == lcdPkg::CMD_CLEAR);
    assign settleLast = isClear ? CNT_W'(CLEAR_SETTLE_CYCLES - 1) : CNT_W'(SETTLE_CYCLES - 1);

    ////////////////////////////////////////////////////////////
    // Setup, enable pulse and settle

    always_ff @(posedge iCLK or negedge iRST_N)
    begin
        if (!iRST_N)
        begin
            state   <= lcdPkg::WR_IDLE;
            cnt     <= '0;
            readyQ  <= 1'b0;                   // Rises one cycle after reset
            lcdEn   <= 1'b0;
            lcdRs   <= 1'b0;
            lcdData <= '0;
        end
        else
        begin
            case (state)
                lcdPkg::WR_IDLE:
                begin
                    if (cmd.valid && readyQ)
                    begin
                        lcdData <= cmd.data;   // Pins set up before enable
                        lcdRs   <= cmd.rs;
                        readyQ  <= 1'b0;
                        state   <= lcdPkg::WR_SETUP;
                    end
                    else
                    begin
                        readyQ <= 1'b1;
                    end
                end
                lcdPkg::WR_SETUP:
                begin
                    lcdEn <= 1'b1;
                    cnt   <= '0;
                    state <= lcdPkg::WR_PULSE;
                end
                lcdPkg::WR_PULSE:
                begin
                    if (cnt == CNT_W'(EN_WIDTH_CYCLES - 1))
                    begin
                        lcdEn <= 1'b0;         // LCD latches on this fall
                        cnt   <= '0;
                        state <= lcdPkg::WR_SETTLE;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default:
                begin
                    if (cnt == settleLast)
                    begin
                        readyQ <= 1'b1;
                        state  <= lcdPkg::WR_IDLE;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    pinsHeld: assert property (
        @(posedge iCLK) disable iff (!iRST_N)
        lcdEn |-> $stable(lcdData) && $stable(lcdRs)
    )
    else
    begin
        $error("lcdBusWriter: data or rs moved during enable");
    end

endmodule

// ==== hdl/lcdTop.sv ====
`timescale 1ns/1ns

module lcdTop
#(
    parameter int POWER_WAIT_CYCLES   = 1_000_000,  // 20 ms at 50 MHz
    parameter int EN_WIDTH_CYCLES     = 25,         // 500 ns
    parameter int SETTLE_CYCLES       = 2_500,      // 50 us
    parameter int CLEAR_SETTLE_CYCLES = 100_000     // 2 ms for clear display
)
(
    input  logic            iCLK,
    input  logic            iRST_N,
    input  logic            wrEn,
    input  lcdPkg::lcdAddrT wrAddr,
    input  lcdPkg::lcdByteT wrChar,
    input  logic            refresh,
    output logic            busy,
    output lcdPkg::lcdByteT lcdData,
    output logic            lcdRs,
    output logic            lcdEn
);

    lcdPkg::lcdAddrT rdAddr;
    lcdPkg::lcdByteT rdChar;

    lcdCmdIf cmdBus ();                         // Sequencer to writer

    lcdScreenBuffer screenBufferInst
    (
        .iCLK   (iCLK),
        .iRST_N (iRST_N),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrChar (wrChar),
        .rdAddr (rdAddr),
        .rdChar (rdChar)
    );

    lcdSequencer #(
        .POWER_WAIT_CYCLES (POWER_WAIT_CYCLES)
    ) sequencerInst (
        .iCLK    (iCLK),
        .iRST_N  (iRST_N),
        .refresh (refresh),
        .rdChar  (rdChar),
        .rdAddr  (rdAddr),
        .busy    (busy),
        .cmd     (cmdBus.src)
    );

    lcdBusWriter #(
        .EN_WIDTH_CYCLES     (EN_WIDTH_CYCLES),
        .SETTLE_CYCLES       (SETTLE_CYCLES),
        .CLEAR_SETTLE_CYCLES (CLEAR_SETTLE_CYCLES)
    ) busWriterInst (
        .iCLK    (iCLK),
        .iRST_N  (iRST_N),
        .cmd     (cmdBus.snk),
        .lcdData (lcdData),
        .lcdRs   (lcdRs),
        .lcdEn   (lcdEn)
    );

endmodule

// ==== bench/tbLcdTop.sv ====
`timescale 1ns/1ns

module tbLcdTop;

    localparam int PERIOD       = 4;
    localparam int POWER_WAIT   = 20;
    localparam int EN_WIDTH     = 3;
    localparam int SETTLE       = 5;
    localparam int CLEAR_SETTLE = 12;
    localparam int REPAINT_LEN  = 2 * lcdPkg::LINE_LEN + 2;       // Two address commands
    localparam int NUM_TABLE    = 5;
    localparam int QUIET_CYCLES = 2 * (1 + EN_WIDTH + CLEAR_SETTLE);
    localparam longint WATCHDOG_NS = longint'((NUM_TABLE + 1) * (lcdPkg::INIT_LEN + 34) *
                                     (1 + EN_WIDTH + CLEAR_SETTLE) + POWER_WAIT) * 2 * PERIOD * 2;

    typedef struct
    {
        int nWrites;                            // Random buffer writes
        int busyPulses;                         // Refresh pulses while busy
        bit midReset;                           // Reset during the repaint
        int expItems;                           // Items logged after the start
    } testT;

    testT tests [NUM_TABLE] = '{
        '{6,  0, 1'b0, 34},
        '{12, 0, 1'b0, 34},
        '{4,  3, 1'b0, 68},                     // Collapsed into one more repaint
        '{8,  0, 1'b1, 38},                     // Init commands plus a blank repaint
        '{10, 0, 1'b0, 34}
    };

    logic            iCLK = 1'b0;
    logic            iRST_N;
    logic            wrEn;
    lcdPkg::lcdAddrT wrAddr;
    lcdPkg::lcdByteT wrChar;
    logic            refresh;
    logic            busy;
    lcdPkg::lcdByteT lcdData;
    logic            lcdRs;
    logic            lcdEn;

    int              errors = 0;
    int              checks = 0;
    logic            logRs [$];
    lcdPkg::lcdByteT logData [$];
    time             logTime [$];
    lcdPkg::lcdByteT shadow [32];               // Screen as the LCD shows it
    lcdPkg::lcdByteT expScreen [32];            // Screen from the testbench's writes
    lcdPkg::lcdAddrT cursor = '0;
    bit              highSeen = 1'b0;
    bit              fallSeen = 1'b0;
    bit              lastClear = 1'b0;
    time             riseT;
    time             fallT;
    int              busyFalls = 0;             // One per finished repaint
    time             busyFallT;

    lcdTop #(
        .POWER_WAIT_CYCLES   (POWER_WAIT),
        .EN_WIDTH_CYCLES     (EN_WIDTH),
        .SETTLE_CYCLES       (SETTLE),
        .CLEAR_SETTLE_CYCLES (CLEAR_SETTLE)
    ) dut_i (
        .iCLK    (iCLK),
        .iRST_N  (iRST_N),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrChar  (wrChar),
        .refresh (refresh),
        .busy    (busy),
        .lcdData (lcdData),
        .lcdRs   (lcdRs),
        .lcdEn   (lcdEn)
    );

    always #(PERIOD / 2) iCLK = ~iCLK;

    ////////////////////////////////////////////////////////////
    // Pin-level LCD model

    always @(posedge lcdEn)
    begin
        int gap;
        int minGap;
        riseT    = $time;
        highSeen = 1'b1;
        if (fallSeen)
        begin
            gap    = int'((riseT - fallT) / PERIOD);
            minGap = (lastClear ? CLEAR_SETTLE : SETTLE) + 1;
            if (gap < minGap)
            begin
                $display("Enable rose %0d cycles after the last fall at %0t, needs %0d",
                         gap, $time, minGap);
                errors++;
            end
        end
    end

    always @(negedge lcdEn)
    begin
        if (highSeen)                           // Skips the x to 0 at reset
        begin
            highSeen = 1'b0;
            fallSeen = 1'b1;
            fallT    = $time;
            checkCount("lcdEn width", int'((fallT - riseT) / PERIOD), EN_WIDTH);
            logRs.push_back(lcdRs);
            logData.push_back(lcdData);
            logTime.push_back($time);
            lastClear = !lcdRs && (lcdData == lcdPkg::CMD_CLEAR);
            if (lcdRs)
            begin
                shadow[cursor] = lcdData;
                cursor++;
            end
            else if (lcdData == lcdPkg::CMD_LINE1_ADDR)
                cursor = 5'd0;
            else if (lcdData == lcdPkg::CMD_LINE2_ADDR)
                cursor = 5'd16;
            else if (lastClear)
            begin
                foreach (shadow[i])
                    shadow[i] = lcdPkg::BLANK_CHAR;
                cursor = 5'd0;
            end
        end
    end

    // End of a repaint as the host sees it
    always @(negedge busy)
    begin
        busyFalls++;
        busyFallT = $time;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic checkByte(input string name, input lcdPkg::lcdByteT got,
                             input lcdPkg::lcdByteT exp);
        checks++;
        if (got !== exp)
        begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic checkRs(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and checking helpers

    task automatic waitBusy(input logic level);
        do
            @(negedge iCLK);                    // busy is stable here
        while (busy !== level);
    endtask

    task automatic waitItems(input int n);
        while (logData.size() < n)
            @(negedge iCLK);
    endtask

    task automatic writeChar(input lcdPkg::lcdAddrT addr, input lcdPkg::lcdByteT ch);
        @(posedge iCLK);
        wrEn          <= 1'b1;
        wrAddr        <= addr;
        wrChar        <= ch;
        expScreen[addr] = ch;
    endtask

    task automatic pulseRefresh();
        @(posedge iCLK);
        refresh <= 1'b1;
        @(posedge iCLK);
        refresh <= 1'b0;
    endtask

    task automatic checkInit(input int base);
        lcdPkg::lcdByteT initCmds [lcdPkg::INIT_LEN];
        initCmds = '{lcdPkg::CMD_FUNCTION_SET, lcdPkg::CMD_DISPLAY_ON,
                     lcdPkg::CMD_CLEAR, lcdPkg::CMD_ENTRY_MODE};
        for (int i = 0; i < lcdPkg::INIT_LEN; i++)
        begin
            checkByte($sformatf("init item %0d", i), logData[base + i], initCmds[i]);
            checkRs($sformatf("init rs %0d", i), logRs[base + i], 1'b0);
        end
    endtask

    task automatic checkRepaint(input int base);
        checkByte("line 1 address", logData[base], lcdPkg::CMD_LINE1_ADDR);
        checkRs("line 1 address rs", logRs[base], 1'b0);
        checkByte("line 2 address", logData[base + 17], lcdPkg::CMD_LINE2_ADDR);
        checkRs("line 2 address rs", logRs[base + 17], 1'b0);
        for (int i = 0; i < lcdPkg::LINE_LEN; i++)
        begin
            checkByte($sformatf("line 1 char %0d", i), logData[base + 1 + i], expScreen[i]);
            checkRs($sformatf("line 1 rs %0d", i), logRs[base + 1 + i], 1'b1);
            checkByte($sformatf("line 2 char %0d", i), logData[base + 18 + i],
                      expScreen[16 + i]);
            checkRs($sformatf("line 2 rs %0d", i), logRs[base + 18 + i], 1'b1);
        end
    endtask

    // Settles, then checks the item count, the end of busy and the LCD's screen
    task automatic finishTest(input string label, input int startIdx, input int expItems,
                              input int startFalls, input int expFalls,
                              input int firstErr);
        time lastFall;
        waitBusy(1'b0);
        repeat (QUIET_CYCLES) @(negedge iCLK);
        lastFall = logTime[logTime.size() - 1];
        checkCount("items logged", logData.size() - startIdx, expItems);
        checkCount("busy falls", busyFalls - startFalls, expFalls);
        // Last char accepted one setup cycle before its enable pulse
        checkCount("busy fall to last lcdEn fall", int'((lastFall - busyFallT) / PERIOD),
                   1 + EN_WIDTH);
        foreach (shadow[i])
            checkByte($sformatf("shadow cell %0d", i), shadow[i], expScreen[i]);
        $display("Test %s finished with %0d errors, last item at %0t", label,
                 errors - firstErr, lastFall);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial
    begin
        int base;
        int startIdx;
        int startFalls;
        int nRep;
        int firstErr;
        iRST_N  = 1'b0;
        wrEn    = 1'b0;
        wrAddr  = '0;
        wrChar  = '0;
        refresh = 1'b0;
        void'($urandom(32'hda6c_a670));
        foreach (expScreen[i])
            expScreen[i] = lcdPkg::BLANK_CHAR;
        repeat (2) @(posedge iCLK);
        iRST_N <= 1'b1;

        waitItems(lcdPkg::INIT_LEN + REPAINT_LEN);  // Init and automatic repaint
        checkInit(0);
        checkRepaint(lcdPkg::INIT_LEN);
        finishTest("power-up", 0, lcdPkg::INIT_LEN + REPAINT_LEN, 0, 1, 0);

        for (int t = 0; t < NUM_TABLE; t++)
        begin
            firstErr = errors;
            waitBusy(1'b0);
            for (int w = 0; w < tests[t].nWrites; w++)
                writeChar(lcdPkg::lcdAddrT'($urandom % 32),
                          lcdPkg::lcdByteT'(8'h21 + $urandom % 94));
            @(posedge iCLK);
            wrEn <= 1'b0;
            base       = logData.size();
            startIdx   = base;
            startFalls = busyFalls;
            pulseRefresh();
            if (tests[t].busyPulses > 0)
            begin
                waitBusy(1'b1);
                repeat (tests[t].busyPulses) pulseRefresh();
            end
            if (tests[t].midReset)
            begin
                waitItems(base + 10);           // Enable is low in the settle phase
                @(posedge iCLK);
                iRST_N <= 1'b0;
                repeat (2) @(posedge iCLK);
                iRST_N <= 1'b1;
                base     = logData.size();
                startIdx = base;
                foreach (expScreen[i])
                    expScreen[i] = lcdPkg::BLANK_CHAR;
                waitItems(base + lcdPkg::INIT_LEN);
                checkInit(base);
                base += lcdPkg::INIT_LEN;
            end
            nRep = (tests[t].expItems - (tests[t].midReset ? lcdPkg::INIT_LEN : 0))
                   / REPAINT_LEN;
            waitItems(base + REPAINT_LEN * nRep);
            for (int r = 0; r < nRep; r++)
                checkRepaint(base + REPAINT_LEN * r);
            finishTest($sformatf("%0d", t), startIdx, tests[t].expItems, startFalls, nRep,
                       firstErr);
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TABLE + 1, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the LCD sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/lcdPkg.sv
hdl/lcdCmdIf.sv
hdl/lcdScreenBuffer.sv
hdl/lcdSequencer.sv
hdl/lcdBusWriter.sv
hdl/lcdTop.sv
bench/tbLcdTop.sv
